//--- hdl/digit_pkg.sv
package digit_pkg;

    // ------------------------------
    // Widths and sizes

    localparam int nibble_w      = 4;
    localparam int depth         = 8;
    localparam int key_w         = 4;

    // Each digit stays lit for 2 ** scan_div_bits cycles
    localparam int scan_div_bits = 3;

    localparam int digit_idx_w   = $clog2(depth);
    localparam int scan_cnt_w    = digit_idx_w + scan_div_bits;

    // ------------------------------
    // Types

    typedef logic [nibble_w - 1:0] nibble_t;

    // One-hot, active high
    typedef logic [depth    - 1:0] digit_sel_t;

    // Segment a at bit 7 down to the dot at bit 0
    typedef logic [           7:0] segments_t;

    typedef logic [key_w    - 1:0] key_t;
    typedef logic [           3:0] table_index_t;

    typedef struct packed
    {
        logic    valid;
        nibble_t data;
    } nibble_stream_t;

    // ------------------------------
    // Fixed permutation of all 16 nibble values

    localparam nibble_t symbol_table [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

endpackage

//--- hdl/key_push_detect.sv
module key_push_detect
(
    input  logic            clk,
    input  logic            arst_n,
    input  digit_pkg::key_t key,
    output logic            push
);

    digit_pkg::key_t key_meta;
    digit_pkg::key_t key_sync;

    logic any_key;
    logic any_key_q;

    // Any key down, after synchronization
    assign any_key = | key_sync;

    // ------------------------------
    // Two-flop synchronizer

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_meta <= '0;
            key_sync <= '0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    // ------------------------------
    // Rising edge of the OR, one cycle wide

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            any_key_q <= 1'b0;
            push      <= 1'b0;
        end
        else
        begin
            any_key_q <= any_key;
            push      <= any_key & ~any_key_q;  // held key gives one push only
        end
    end

endmodule

//--- hdl/symbol_source.sv
module symbol_source
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      push,
    output digit_pkg::nibble_stream_t src
);

    digit_pkg::table_index_t index;

    logic               src_valid;
    digit_pkg::nibble_t src_data;

    // ------------------------------
    // Table index, advances once per push

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            index <= '0;
        end
        else if (push)
        begin
            // Wraps after the last entry
            index <= index + 1'b1;
        end
    end

    // ------------------------------
    // Output item

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            src_valid <= 1'b0;
        end
        else
        begin
            src_valid <= push;
        end
    end

    // Data only meaningful with src_valid
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            src_data <= digit_pkg::symbol_table[index];
        end
    end

    assign src.valid = src_valid;
    assign src.data  = src_data;

endmodule

//--- hdl/shift_register_with_valid_and_debug.sv
module shift_register_with_valid_and_debug
(
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  digit_pkg::nibble_stream_t                 src,
    output digit_pkg::nibble_stream_t                 shift_out,
    output logic [digit_pkg::depth - 1:0]             dbg_valid,
    output digit_pkg::nibble_t [digit_pkg::depth - 1:0] dbg_data
);

    // Stage 0 holds the newest entry
    logic [digit_pkg::depth - 1:0]               stage_valid;
    digit_pkg::nibble_t [digit_pkg::depth - 1:0] stage_data;

    logic               out_valid;
    digit_pkg::nibble_t out_data;

    // ------------------------------
    // Valid chain and shifted-out flag

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            stage_valid <= '0;
            out_valid   <= 1'b0;
        end
        else if (src.valid)
        begin
            stage_valid <= { stage_valid[digit_pkg::depth - 2:0], 1'b1 };
            out_valid   <= stage_valid[digit_pkg::depth - 1];
        end
        else
        begin
            out_valid   <= 1'b0;
        end
    end

    // ------------------------------
    // Data chain

    always_ff @(posedge clk)
    begin
        if (src.valid)
        begin
            stage_data <= { stage_data[digit_pkg::depth - 2:0], src.data };
            out_data   <= stage_data[digit_pkg::depth - 1];
        end
    end

    assign shift_out.valid = out_valid;
    assign shift_out.data  = out_data;

    // Debug view of every stage
    assign dbg_valid = stage_valid;
    assign dbg_data  = stage_data;

endmodule

//--- hdl/seven_segment_display.sv
module seven_segment_display
(
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic [digit_pkg::depth - 1:0]               entry_valid,
    input  digit_pkg::nibble_t [digit_pkg::depth - 1:0] entry_data,
    output digit_pkg::segments_t                        abcdefgh,
    output digit_pkg::digit_sel_t                       digit
);

    logic [digit_pkg::scan_cnt_w  - 1:0] scan_cnt;
    logic [digit_pkg::digit_idx_w - 1:0] digit_idx;

    logic                 sel_valid;
    digit_pkg::nibble_t   sel_data;
    digit_pkg::segments_t sel_segments;

    // ------------------------------
    // Hex shapes, abcdefgh order, dot off

    function automatic digit_pkg::segments_t hex_to_segments
    (
        input digit_pkg::nibble_t value
    );
        digit_pkg::segments_t seg;

        case (value)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;  // f
        endcase

        return seg;
    endfunction

    // ------------------------------
    // Scan counter

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scan_cnt <= '0;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Upper bits pick the digit
    assign digit_idx = scan_cnt[digit_pkg::scan_cnt_w - 1:digit_pkg::scan_div_bits];

    assign sel_valid = entry_valid[digit_idx];
    assign sel_data  = entry_data[digit_idx];

    // Empty stage stays dark
    always_comb
    begin
        if (sel_valid)
            sel_segments = hex_to_segments(sel_data);
        else
            sel_segments = '0;
    end

    // ------------------------------
    // Digit select and segments registered together

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            digit    <= digit_pkg::digit_sel_t'(1);
            abcdefgh <= '0;
        end
        else
        begin
            digit    <= digit_pkg::digit_sel_t'(1) << digit_idx;
            abcdefgh <= sel_segments;
        end
    end

endmodule

//--- hdl/display_top.sv
module display_top
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  digit_pkg::key_t           key,
    output digit_pkg::segments_t      abcdefgh,
    output digit_pkg::digit_sel_t     digit,
    output digit_pkg::nibble_stream_t out
);

    logic                      push;
    digit_pkg::nibble_stream_t src;

    logic [digit_pkg::depth - 1:0]               dbg_valid;
    digit_pkg::nibble_t [digit_pkg::depth - 1:0] dbg_data;

    logic [digit_pkg::depth - 1:0]               entry_valid;
    digit_pkg::nibble_t [digit_pkg::depth - 1:0] entry_data;

    // ------------------------------
    // Key to stream item

    key_push_detect u_key_push_detect
    (
        .clk    (clk),
        .arst_n (arst_n),
        .key    (key),
        .push   (push)
    );

    symbol_source u_symbol_source
    (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (push),
        .src    (src)
    );

    // ------------------------------
    // Stage chain

    shift_register_with_valid_and_debug u_shift_register
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .src       (src),
        .shift_out (out),
        .dbg_valid (dbg_valid),
        .dbg_data  (dbg_data)
    );

    // Newest entry goes to the rightmost digit
    for (genvar i = 0; i < digit_pkg::depth; i++)
    begin : gen_mirror
        assign entry_valid[i] = dbg_valid[digit_pkg::depth - 1 - i];
        assign entry_data[i]  = dbg_data[digit_pkg::depth - 1 - i];
    end

    // ------------------------------
    // Readout

    seven_segment_display u_display
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .entry_valid (entry_valid),
        .entry_data  (entry_data),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

endmodule

//--- sim/display_assert.sv
module display_assert
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sel_valid,
    input  digit_pkg::segments_t  abcdefgh,
    input  digit_pkg::digit_sel_t digit
);

    int onehot_fails = 0;
    int blank_fails  = 0;
    int dot_fails    = 0;

    // Exactly one digit enabled at a time
    digit_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(digit))
    else
    begin
        $error("digit select is not one-hot: %b", digit);
        onehot_fails++;
    end

    // Segments are registered one cycle after the selection
    blank_when_invalid: assert property (@(posedge clk) disable iff (!arst_n)
        !sel_valid |=> abcdefgh == '0)
    else
    begin
        $error("segments lit for an empty entry: %b", abcdefgh);
        blank_fails++;
    end

    dot_off: assert property (@(posedge clk) disable iff (!arst_n) abcdefgh[0] == 1'b0)
    else
    begin
        $error("dot segment lit");
        dot_fails++;
    end

endmodule

//--- sim/display_checker.sv
module display_checker
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  digit_pkg::key_t           key,
    input  digit_pkg::segments_t      abcdefgh,
    input  digit_pkg::digit_sel_t     digit,
    input  digit_pkg::nibble_stream_t out,
    output int                        errors,
    output int                        pending,
    output logic                      settled
);

    // Symbols in push order
    localparam digit_pkg::nibble_t symbols [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // Hex shapes 0 to f, segment a in the top bit
    localparam digit_pkg::segments_t shapes [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    string test_name = "none";

    // Model stages, stage 0 newest
    logic [digit_pkg::depth - 1:0] model_valid;
    digit_pkg::nibble_t            model_data [digit_pkg::depth];
    digit_pkg::nibble_t            out_queue [$];

    int                    press_cnt;
    int                    quiet_cnt;
    int                    hold_cnt;
    logic                  scan_started;
    digit_pkg::key_t       key_q;
    digit_pkg::digit_sel_t digit_q;

    task automatic model_push();
        if (model_valid[digit_pkg::depth - 1])
            out_queue.push_back(model_data[digit_pkg::depth - 1]);
        for (int i = digit_pkg::depth - 1; i > 0; i--)
            model_data[i] = model_data[i - 1];
        model_data[0] = symbols[press_cnt % 16];
        model_valid   = {model_valid[digit_pkg::depth - 2:0], 1'b1};
        press_cnt++;
    endtask

    task automatic check_out();
        digit_pkg::nibble_t expected;

        if (out_queue.size() == 0)
        begin
            errors++;
            $display("Unexpected out value %h during %s", out.data, test_name);
        end
        else
        begin
            expected = out_queue.pop_front();
            if (out.data !== expected)
            begin
                errors++;
                $display("Error %s: out expected %h actual %h", test_name, expected, out.data);
            end
        end
    endtask

    task automatic check_scan();
        if (digit != digit_q)
        begin
            if (digit != {digit_q[digit_pkg::depth - 2:0], digit_q[digit_pkg::depth - 1]}
                || (scan_started && hold_cnt != (1 << digit_pkg::scan_div_bits)))
            begin
                errors++;
                $display("Scan order broken during %s: digit %b after %b held %0d cycles",
                         test_name, digit, digit_q, hold_cnt);
            end
            scan_started = 1'b1;
            hold_cnt     = 1;
            digit_q      = digit;
        end
        else
        begin
            hold_cnt++;
            // A stuck scan never moves to the next digit
            if (hold_cnt == (1 << digit_pkg::scan_div_bits) + 2)
            begin
                errors++;
                $display("Scan stopped during %s: digit %b held for %0d cycles",
                         test_name, digit, hold_cnt);
            end
        end
    endtask

    task automatic check_segments();
        int                   stage;
        digit_pkg::segments_t expected;

        stage = -1;
        // Digit i shows stage depth-1-i
        for (int i = 0; i < digit_pkg::depth; i++)
            if (digit == (digit_pkg::digit_sel_t'(1) << i))
                stage = digit_pkg::depth - 1 - i;
        if (stage >= 0)
        begin
            expected = model_valid[stage] ? shapes[model_data[stage]] : '0;
            if (abcdefgh !== expected)
            begin
                errors++;
                $display("Error %s: segments for digit %b expected %b actual %b",
                         test_name, digit, expected, abcdefgh);
            end
        end
    endtask

    // ------------------------------
    // Sampled on the rising edge, keys and outputs stable there

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            model_valid  = '0;
            press_cnt    = 0;
            quiet_cnt    = 0;
            hold_cnt     = 0;
            scan_started = 1'b0;
            key_q        = '0;
            digit_q      = digit_pkg::digit_sel_t'(1);
            errors       = 0;
            pending      = 0;
            settled      = 1'b0;
            out_queue.delete();
        end
        else
        begin
            if (key != key_q)
                quiet_cnt = 0;
            else if (quiet_cnt < 1000)
                quiet_cnt++;
            if ((|key) && !(|key_q))
                model_push();
            key_q = key;
            if (out.valid)
                check_out();
            check_scan();
            if (quiet_cnt >= 8)
                check_segments();
            pending = out_queue.size();
            settled = (quiet_cnt >= 8);
        end
    end

endmodule

//--- sim/tb_display_top.sv
bind seven_segment_display display_assert u_display_assert
(
    .clk       (clk),
    .arst_n    (arst_n),
    .sel_valid (sel_valid),
    .abcdefgh  (abcdefgh),
    .digit     (digit)
);

module tb_display_top;

    logic                      clk    = 1'b0;
    logic                      arst_n = 1'b0;
    digit_pkg::key_t           key    = '0;
    digit_pkg::segments_t      abcdefgh;
    digit_pkg::digit_sel_t     digit;
    digit_pkg::nibble_stream_t out;

    int   checker_errors;
    int   pending;
    logic settled;

    logic [31:0] lfsr_state = 32'hd114_d50e;
    int          tests_run  = 0;
    int          tests_bad  = 0;
    int          error_base = 0;
    bit          aborted    = 1'b0;

    always #10 clk = ~clk;

    display_top u_dut
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .key      (key),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .out      (out)
    );

    display_checker u_checker
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .key      (key),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .out      (out),
        .errors   (checker_errors),
        .pending  (pending),
        .settled  (settled)
    );

    // ------------------------------
    // Stimulus helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'hd000_0001;
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Called right after a falling edge
    task automatic press_keys(input digit_pkg::key_t keys, input int hold, input int gap);
        key = keys;
        repeat (hold) @(negedge clk);
        key = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic press_random();
        int keys;
        int hold;
        int gap;

        take_bits(digit_pkg::key_w, keys);
        take_bits(3, hold);
        take_bits(3, gap);
        if (keys == 0)
            keys = 1;
        press_keys(digit_pkg::key_t'(keys), hold + 4, gap + 4);
    endtask

    function automatic int all_errors();
        return checker_errors
             + u_dut.u_display.u_display_assert.onehot_fails
             + u_dut.u_display.u_display_assert.blank_fails
             + u_dut.u_display.u_display_assert.dot_fails;
    endfunction

    task automatic wait_settled(input int limit, output bit ok);
        int cycles;

        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            if (settled && pending == 0)
                ok = 1'b1;
        end
    endtask

    task automatic start_test(input string name);
        u_checker.test_name = name;
        error_base = all_errors();
    endtask

    // Settle, then one more full scan so every digit is compared
    task automatic finish_test(input string name);
        bit ok;
        int delta;

        wait_settled(200, ok);
        if (!ok)
        begin
            $display("Timeout in %s: outputs never settled or out values are missing", name);
            aborted = 1'b1;
        end
        else
        begin
            repeat (80) @(negedge clk);
            delta = all_errors() - error_base;
            tests_run++;
            if (delta != 0)
                tests_bad++;
            $display("test %s: %0d errors", name, delta);
        end
    endtask

    // ------------------------------
    // Test sequence

    initial
    begin
        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        start_test("reset_idle");
        repeat (60) @(negedge clk);
        finish_test("reset_idle");

        if (!aborted)
        begin
            start_test("partial_fill");
            repeat (5) press_random();
            finish_test("partial_fill");
        end

        if (!aborted)
        begin
            start_test("held_keys");
            press_keys(4'b1111, 40, 6);
            // Overlapping presses, never all released
            key = 4'b0100;
            repeat (6) @(negedge clk);
            key = 4'b0110;
            repeat (6) @(negedge clk);
            key = 4'b0010;
            repeat (4) @(negedge clk);
            press_keys(4'b0011, 4, 6);
            finish_test("held_keys");
        end

        if (!aborted)
        begin
            start_test("shift_out");
            repeat (6) press_random();
            finish_test("shift_out");
        end

        if (!aborted)
        begin
            start_test("table_wrap");
            repeat (10) press_random();
            finish_test("table_wrap");
        end

        if (!aborted)
        begin
            start_test("idle_scan");
            repeat (300) @(negedge clk);
            finish_test("idle_scan");
        end

        $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, all_errors());
        if (aborted || tests_bad != 0 || all_errors() != 0)
            $display("Test failed");
        else
            $display("Test completed successfully");
        $finish;
    end

endmodule

//--- all.f
hdl/digit_pkg.sv
hdl/key_push_detect.sv
hdl/symbol_source.sv
hdl/shift_register_with_valid_and_debug.sv
hdl/seven_segment_display.sv
hdl/display_top.sv
sim/display_assert.sv
sim/display_checker.sv
sim/tb_display_top.sv

//--- run.sh
#!/bin/sh
# Build and run the display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_display_top -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build returned an error"
    exit 1
fi

# Raise the error limit so assertion failures do not stop the run early
output=$(./obj_dir/Vtb_display_top +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
